// ==== src/mont_pkg.sv ====
package mont_pkg;

  // Operand, modulus and result width
  localparam int DATA_LENGTH = 32;

  // Exponent n has to hold 0 up to DATA_LENGTH
  localparam int EXP_WIDTH = 6;

  // One extra bit since the running sum stays below 2m
  localparam int SUM_WIDTH = DATA_LENGTH + 1;

  // Largest legal exponent at exponent width
  localparam logic [EXP_WIDTH-1:0] MAX_EXP = EXP_WIDTH'(DATA_LENGTH);

  // Reduction core states
  typedef enum logic [1:0] {
    CORE_LOAD,    // Waiting for a pending job
    CORE_REDUCE,  // One add-and-halve step per cycle
    CORE_FINISH   // Hand sum over to the final stage
  } core_state_e;

endpackage : mont_pkg

// ==== src/mont_operand_stage.sv ====
module mont_operand_stage (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] x_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] y_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] m_i,
  input  logic [mont_pkg::EXP_WIDTH-1:0]   m_bl_i,
  input  logic                             job_take_i,
  output logic                             busy_o,
  output logic                             job_valid_o,
  output logic [mont_pkg::DATA_LENGTH-1:0] job_x_o,
  output logic [mont_pkg::DATA_LENGTH-1:0] job_y_o,
  output logic [mont_pkg::DATA_LENGTH-1:0] job_m_o,
  output logic [mont_pkg::EXP_WIDTH-1:0]   job_n_o,
  output logic                             job_bad_o
);

  logic                             full_q;   // Pending slot occupied
  logic                             accept;
  logic                             m_even;
  logic                             n_zero;
  logic                             n_large;
  logic                             m_wide;
  logic                             bad_d;
  logic [mont_pkg::DATA_LENGTH-1:0] x_q;
  logic [mont_pkg::DATA_LENGTH-1:0] y_q;
  logic [mont_pkg::DATA_LENGTH-1:0] m_q;
  logic [mont_pkg::EXP_WIDTH-1:0]   n_q;
  logic                             bad_q;

  // A start only counts while the slot is free
  assign accept = start_i && !full_q;

  // Job checks on the incoming operands
  always_comb begin
    m_even  = !m_i[0];                   // Montgomery needs an odd modulus
    n_zero  = (m_bl_i == '0);
    n_large = (m_bl_i > mont_pkg::MAX_EXP);
    m_wide  = ((m_i >> m_bl_i) != '0);   // m not below 2^n
    bad_d   = m_even || n_zero || n_large || m_wide;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (job_take_i) begin
      full_q <= 1'b0;                    // Core copied the job
    end
  end

  // Slot contents, written only on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      x_q   <= x_i;
      y_q   <= y_i;
      m_q   <= m_i;
      n_q   <= m_bl_i;
      bad_q <= bad_d;
    end
  end

  assign busy_o      = full_q;
  assign job_valid_o = full_q;
  assign job_x_o     = x_q;
  assign job_y_o     = y_q;
  assign job_m_o     = m_q;
  assign job_n_o     = n_q;
  assign job_bad_o   = bad_q;

endmodule : mont_operand_stage

// ==== src/mont_serial_core.sv ====
module mont_serial_core (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             job_valid_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] job_x_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] job_y_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] job_m_i,
  input  logic [mont_pkg::EXP_WIDTH-1:0]   job_n_i,
  input  logic                             job_bad_i,
  output logic                             job_take_o,
  output logic                             done_o,
  output logic [mont_pkg::SUM_WIDTH-1:0]   sum_o,
  output logic [mont_pkg::DATA_LENGTH-1:0] fin_m_o,
  output logic                             fin_bad_o
);

  mont_pkg::core_state_e            state_q;
  mont_pkg::core_state_e            state_d;
  logic [mont_pkg::EXP_WIDTH-1:0]   idx_q;    // Steps done so far
  logic [mont_pkg::DATA_LENGTH-1:0] x_q;      // Shifted right once per step
  logic [mont_pkg::DATA_LENGTH-1:0] y_q;
  logic [mont_pkg::DATA_LENGTH-1:0] m_q;
  logic [mont_pkg::EXP_WIDTH-1:0]   n_q;
  logic                             bad_q;
  logic [mont_pkg::SUM_WIDTH-1:0]   s_q;      // Running sum S
  logic [mont_pkg::SUM_WIDTH-1:0]   s_next;
  logic                             last_step;

  // One bit of the reduction: S = (S + x_b*y + q*m) / 2 with q = parity
  function automatic logic [mont_pkg::SUM_WIDTH-1:0] reduce_step(
    input logic [mont_pkg::SUM_WIDTH-1:0]   s,
    input logic                             x_b,
    input logic [mont_pkg::DATA_LENGTH-1:0] y,
    input logic [mont_pkg::DATA_LENGTH-1:0] m
  );
    logic [mont_pkg::SUM_WIDTH:0] t_add;
    logic [mont_pkg::SUM_WIDTH:0] t_red;
    t_add = {1'b0, s} + {2'b00, y & {mont_pkg::DATA_LENGTH{x_b}}};
    t_red = t_add + ({2'b00, m} & {(mont_pkg::SUM_WIDTH + 1){t_add[0]}});
    return t_red[mont_pkg::SUM_WIDTH:1];  // Even by construction
  endfunction

  assign job_take_o = (state_q == mont_pkg::CORE_LOAD) && job_valid_i;
  assign last_step  = (idx_q == n_q - 1);
  assign s_next     = reduce_step(s_q, x_q[0], y_q, m_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      mont_pkg::CORE_LOAD: begin
        if (job_valid_i) begin
          // Rejected jobs bypass the reduction
          state_d = job_bad_i ? mont_pkg::CORE_FINISH : mont_pkg::CORE_REDUCE;
        end
      end
      mont_pkg::CORE_REDUCE: begin
        if (last_step) begin
          state_d = mont_pkg::CORE_FINISH;
        end
      end
      mont_pkg::CORE_FINISH: begin
        state_d = mont_pkg::CORE_LOAD;
      end
      default: begin
        state_d = mont_pkg::CORE_LOAD;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mont_pkg::CORE_LOAD;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      if (job_take_o) begin
        idx_q <= '0;
      end else if (state_q == mont_pkg::CORE_REDUCE) begin
        idx_q <= idx_q + 1;
      end
    end
  end

  // Job copy frees the operand slot for the next start
  always_ff @(posedge clk_i) begin
    if (job_take_o) begin
      x_q   <= job_x_i;
      y_q   <= job_y_i;
      m_q   <= job_m_i;
      n_q   <= job_n_i;
      bad_q <= job_bad_i;
      s_q   <= '0;
    end else if (state_q == mont_pkg::CORE_REDUCE) begin
      x_q <= x_q >> 1;                    // Next bit of x into x_q[0]
      s_q <= s_next;
    end
  end

  assign done_o    = (state_q == mont_pkg::CORE_FINISH);
  assign sum_o     = s_q;
  assign fin_m_o   = m_q;
  assign fin_bad_o = bad_q;

endmodule : mont_serial_core

// ==== src/mont_final_sub.sv ====
module mont_final_sub (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             done_i,
  input  logic [mont_pkg::SUM_WIDTH-1:0]   sum_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] fin_m_i,
  input  logic                             fin_bad_i,
  output logic [mont_pkg::DATA_LENGTH-1:0] result_o,
  output logic                             valid_o,
  output logic                             error_o
);

  logic [mont_pkg::SUM_WIDTH-1:0]   m_ext;
  logic [mont_pkg::SUM_WIDTH-1:0]   diff;
  logic                             sum_ge_m;
  logic [mont_pkg::DATA_LENGTH-1:0] res_d;

  assign m_ext    = {1'b0, fin_m_i};
  assign diff     = sum_i - m_ext;
  assign sum_ge_m = (sum_i >= m_ext);

  // Sum is below 2m, so one subtraction is enough
  always_comb begin
    if (fin_bad_i) begin
      res_d = '0;
    end else if (sum_ge_m) begin
      res_d = diff[mont_pkg::DATA_LENGTH-1:0];
    end else begin
      res_d = sum_i[mont_pkg::DATA_LENGTH-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      error_o  <= 1'b0;
    end else begin
      valid_o <= done_i;                  // Single cycle, follows done
      error_o <= done_i && fin_bad_i;
      if (done_i) begin
        result_o <= res_d;
      end
    end
  end

endmodule : mont_final_sub

// ==== src/mont_mul_top.sv ====
module mont_mul_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] x_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] y_i,
  input  logic [mont_pkg::DATA_LENGTH-1:0] m_i,
  input  logic [mont_pkg::EXP_WIDTH-1:0]   m_bl_i,    // Montgomery exponent n
  output logic [mont_pkg::DATA_LENGTH-1:0] result_o,
  output logic                             valid_o,
  output logic                             error_o,
  output logic                             busy_o
);

  logic                             job_valid;
  logic [mont_pkg::DATA_LENGTH-1:0] job_x;
  logic [mont_pkg::DATA_LENGTH-1:0] job_y;
  logic [mont_pkg::DATA_LENGTH-1:0] job_m;
  logic [mont_pkg::EXP_WIDTH-1:0]   job_n;
  logic                             job_bad;
  logic                             job_take;
  logic                             done;
  logic [mont_pkg::SUM_WIDTH-1:0]   sum;
  logic [mont_pkg::DATA_LENGTH-1:0] fin_m;
  logic                             fin_bad;

  mont_operand_stage i_operand (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .x_i         (x_i),
    .y_i         (y_i),
    .m_i         (m_i),
    .m_bl_i      (m_bl_i),
    .job_take_i  (job_take),
    .busy_o      (busy_o),
    .job_valid_o (job_valid),
    .job_x_o     (job_x),
    .job_y_o     (job_y),
    .job_m_o     (job_m),
    .job_n_o     (job_n),
    .job_bad_o   (job_bad)
  );

  mont_serial_core i_core (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .job_valid_i (job_valid),
    .job_x_i     (job_x),
    .job_y_i     (job_y),
    .job_m_i     (job_m),
    .job_n_i     (job_n),
    .job_bad_i   (job_bad),
    .job_take_o  (job_take),
    .done_o      (done),
    .sum_o       (sum),
    .fin_m_o     (fin_m),
    .fin_bad_o   (fin_bad)
  );

  mont_final_sub i_final (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .done_i    (done),
    .sum_i     (sum),
    .fin_m_i   (fin_m),
    .fin_bad_i (fin_bad),
    .result_o  (result_o),
    .valid_o   (valid_o),
    .error_o   (error_o)
  );

endmodule : mont_mul_top

// ==== tests/mont_mul_asserts.sv ====
module mont_mul_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  valid_i,
  input logic                  error_i,
  input logic                  busy_i,
  input logic                  job_valid_i,
  input mont_pkg::core_state_e core_state_i
);

  // Result strobe is a single cycle pulse
  valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |=> !valid_i)
    else $error("valid_o stayed high for two cycles");

  error_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_i |-> valid_i)
    else $error("error_o high without valid_o");

  // Core only leaves LOAD when a job is pending
  load_needs_job: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_state_i == mont_pkg::CORE_LOAD && !job_valid_i) |=>
      (core_state_i == mont_pkg::CORE_LOAD))
    else $error("Core left CORE_LOAD without a pending job");

  idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !busy_i)
    else $error("busy_o high right after reset release");

endmodule : mont_mul_asserts

bind mont_mul_top mont_mul_asserts i_asserts (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .valid_i      (valid_o),
  .error_i      (error_o),
  .busy_i       (busy_o),
  .job_valid_i  (job_valid),
  .core_state_i (i_core.state_q)
);

// ==== tests/tb_mont_mul.sv ====
module tb_mont_mul;

  localparam int CLK_PERIOD    = 40;
  localparam int JOB_COUNT     = 64;  // Upper bound on jobs across all tests
  localparam int WATCHDOG_TIME =
    JOB_COUNT * (mont_pkg::DATA_LENGTH + 5) * CLK_PERIOD + 4000;
  localparam int IDLE_LIMIT    = 3 * (mont_pkg::DATA_LENGTH + 5);  // Slot plus core, with margin

  logic                             clk_i;
  logic                             rst_ni;
  logic                             start_i;
  logic [mont_pkg::DATA_LENGTH-1:0] x_i;
  logic [mont_pkg::DATA_LENGTH-1:0] y_i;
  logic [mont_pkg::DATA_LENGTH-1:0] m_i;
  logic [mont_pkg::EXP_WIDTH-1:0]   m_bl_i;
  logic [mont_pkg::DATA_LENGTH-1:0] result_o;
  logic                             valid_o;
  logic                             error_o;
  logic                             busy_o;

  integer seed = 20;
  int     cyc = 0;           // Rising edges seen so far
  int     value_errors = 0;
  int     latency_errors = 0;
  int     other_errors = 0;
  int     valid_count = 0;
  int     job_count = 0;
  int     ignored_starts = 0;

  // Expected results, one entry per accepted job, in start order
  logic [31:0] exp_res_q[$];
  logic        exp_err_q[$];
  string       name_q[$];
  int          exp_cyc_q[$];  // -1 where the latency is not fixed

  string       cur_name;
  logic [31:0] cur_res;
  logic        cur_err;
  int          cur_cyc;

  mont_mul_top i_mont_mul_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .x_i      (x_i),
    .y_i      (y_i),
    .m_i      (m_i),
    .m_bl_i   (m_bl_i),
    .result_o (result_o),
    .valid_o  (valid_o),
    .error_o  (error_o),
    .busy_o   (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // x*y mod m, then n halvings mod m gives x*y*2^-n mod m
  function automatic logic [31:0] ref_mont(input logic [31:0] x, input logic [31:0] y,
                                           input logic [31:0] m, input int n);
    logic [63:0] p;
    p = ({32'b0, x} * {32'b0, y}) % {32'b0, m};
    for (int i = 0; i < n; i++) begin
      if (p[0]) begin
        p = p + {32'b0, m};
      end
      p = p >> 1;
    end
    return p[31:0];
  endfunction

  function automatic bit job_is_bad(input logic [31:0] m, input int n);
    return (m[0] == 1'b0) || (n == 0) || (n > mont_pkg::DATA_LENGTH) ||
           (({32'b0, m} >> n) != 64'd0);
  endfunction

  function automatic int bit_len(input logic [31:0] m);
    for (int i = 31; i >= 0; i--) begin
      if (m[i]) begin
        return i + 1;
      end
    end
    return 0;
  endfunction

  function automatic logic [31:0] random_odd_modulus();
    logic [31:0] m;
    m    = $random(seed);
    m[0] = 1'b1;
    if (m < 32'd3) begin
      m = 32'd3;
    end
    return m;
  endfunction

  function automatic logic [31:0] random_below(input logic [31:0] m);
    logic [31:0] r;
    r = $random(seed);
    return r % m;
  endfunction

  // Called at the drive point of the cycle in which start_i is accepted
  task automatic expect_job(input string name, input logic [31:0] x, input logic [31:0] y,
                            input logic [31:0] m, input int n, input bit fixed_lat);
    bit bad;
    bad = job_is_bad(m, n);
    exp_res_q.push_back(bad ? 32'h0 : ref_mont(x, y, m, n));
    exp_err_q.push_back(bad);
    name_q.push_back(name);
    exp_cyc_q.push_back(fixed_lat ? cyc + (bad ? 3 : n + 3) : -1);
    job_count++;
  endtask

  task automatic issue_job(input string name, input logic [31:0] x, input logic [31:0] y,
                           input logic [31:0] m, input int n, input bit fixed_lat);
    while (busy_o) begin
      @(posedge clk_i);
      #5;
    end
    start_i = 1'b1;
    x_i     = x;
    y_i     = y;
    m_i     = m;
    m_bl_i  = n[mont_pkg::EXP_WIDTH-1:0];
    expect_job(name, x, y, m, n, fixed_lat);
    @(posedge clk_i);
    #5;
    start_i = 1'b0;
    // Accepted job now sits in the pending slot
    if (busy_o !== 1'b1) begin
      value_errors++;
      $display("[ERROR] %s: busy_o expected 1, actual %b", name, busy_o);
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_res_q.size() != 0 && waited < IDLE_LIMIT) begin
      @(posedge clk_i);
      #5;
      waited++;
    end
  endtask

  task automatic random_job(input string name, input bit fixed_lat);
    logic [31:0] m;
    m = random_odd_modulus();
    issue_job(name, random_below(m), random_below(m), m, bit_len(m), fixed_lat);
  endtask

  // start_i held high every cycle, only starts seen with busy_o low count
  task automatic hammer_starts(input int cycles);
    logic [31:0] m;
    for (int i = 0; i < cycles; i++) begin
      m       = random_odd_modulus();
      start_i = 1'b1;
      x_i     = random_below(m);
      y_i     = random_below(m);
      m_i     = m;
      m_bl_i  = mont_pkg::EXP_WIDTH'(bit_len(m));
      if (!busy_o) begin
        expect_job("busy_start", x_i, y_i, m, bit_len(m), 1'b0);
      end else begin
        ignored_starts++;
      end
      @(posedge clk_i);
      #5;
    end
    start_i = 1'b0;
  endtask

  // Compare at the falling edge where outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni && valid_o) begin
      valid_count++;
      if (exp_res_q.size() == 0) begin
        other_errors++;
        $display("valid_o pulsed at cycle %0d while no job was outstanding", cyc);
      end else begin
        cur_res  = exp_res_q.pop_front();
        cur_err  = exp_err_q.pop_front();
        cur_name = name_q.pop_front();
        cur_cyc  = exp_cyc_q.pop_front();
        if (result_o !== cur_res) begin
          value_errors++;
          $display("[ERROR] %s: result expected %h, actual %h", cur_name, cur_res, result_o);
        end
        if (error_o !== cur_err) begin
          value_errors++;
          $display("[ERROR] %s: error_o expected %b, actual %b", cur_name, cur_err, error_o);
        end
        if (cur_cyc >= 0 && cyc != cur_cyc) begin
          latency_errors++;
          $display("[ERROR] %s: valid_o cycle expected %0d, actual %0d", cur_name, cur_cyc,
                   cyc);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] m;
    start_i = 1'b0;
    x_i     = '0;
    y_i     = '0;
    m_i     = '0;
    m_bl_i  = '0;
    rst_ni  = 1'b0;
    repeat (2) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #5;

    // Single jobs on an idle pipeline, latency fixed
    repeat (8) begin
      random_job("single", 1'b1);
      wait_idle();
    end

    // Edge values
    m = random_odd_modulus();
    issue_job("x_zero", 32'h0, random_below(m), m, bit_len(m), 1'b1);
    wait_idle();
    issue_job("y_zero", random_below(m), 32'h0, m, bit_len(m), 1'b1);
    wait_idle();
    issue_job("full_width", random_below(32'hFFFF_FFFF), random_below(32'hFFFF_FFFF),
              32'hFFFF_FFFF, 32, 1'b1);
    wait_idle();
    issue_job("m_one", 32'h0, 32'h0, 32'h1, 1, 1'b1);
    wait_idle();

    // Rejected jobs, each followed by a good one
    issue_job("m_even", 32'd5, 32'd7, 32'd100, 7, 1'b1);
    random_job("after_m_even", 1'b0);
    wait_idle();
    issue_job("n_zero", 32'd5, 32'd7, 32'd13, 0, 1'b1);
    random_job("after_n_zero", 1'b0);
    wait_idle();
    issue_job("n_large", 32'd5, 32'd7, 32'd13, 40, 1'b1);
    random_job("after_n_large", 1'b0);
    wait_idle();
    issue_job("m_wide", 32'd5, 32'd7, 32'h0000_0101, 8, 1'b1);
    random_job("after_m_wide", 1'b0);
    wait_idle();

    // Back to back, start as soon as busy_o drops
    repeat (10) begin
      random_job("back_to_back", 1'b0);
    end
    wait_idle();

    hammer_starts(30);
    wait_idle();
    repeat (5) @(posedge clk_i);

    if (exp_res_q.size() != 0) begin
      other_errors++;
      $display("%0d expected results never appeared", exp_res_q.size());
    end
    if (valid_count != job_count) begin
      other_errors++;
      $display("Saw %0d valid_o pulses for %0d accepted jobs", valid_count, job_count);
    end
    if (ignored_starts == 0) begin
      other_errors++;
      $display("No start_i pulse arrived while busy_o was high");
    end

    $display("Errors: value %0d, latency %0d, other %0d", value_errors, latency_errors,
             other_errors);
    if (value_errors + latency_errors + other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_mont_mul

// ==== sources.f ====
src/mont_pkg.sv
src/mont_operand_stage.sv
src/mont_serial_core.sv
src/mont_final_sub.sv
src/mont_mul_top.sv
tests/mont_mul_asserts.sv
tests/tb_mont_mul.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_mont_mul
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
